// ==== common/divPkg.sv ====
package divPkg;

    // Operand width, which also sets the number of iteration steps
    localparam int DATA_W = 32;
    localparam int SQN_W = 7;
    localparam int TAG_W = 6;

    // Partial remainder carries the dividend below and a sign bit on top
    localparam int REM_W = 2 * DATA_W + 1;
    localparam int CNT_W = $clog2(DATA_W);

    typedef logic [DATA_W-1:0] dataT;
    typedef logic [SQN_W-1:0] sqNT;
    typedef logic [TAG_W-1:0] tagT;
    typedef logic [REM_W-1:0] partRemT;
    typedef logic [CNT_W-1:0] stepCntT;

    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } divOpT;

    typedef enum logic [1:0] {
        IDLE,
        ITER,
        FINISH
    } coreStateT;

    // Sequence numbers wrap, so age is the sign of the modular difference
    function automatic logic isYounger(input sqNT sqN, input sqNT branchSqN);
        logic signed [SQN_W-1:0] diff;
        diff = sqN - branchSqN;
        return diff > 0;
    endfunction

endpackage

// ==== source/divIssueSlot.sv ====
module divIssueSlot (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  divPkg::divOpT   inOp,
    input  divPkg::dataT    inSrcA,
    input  divPkg::dataT    inSrcB,
    input  divPkg::sqNT     inSqN,
    input  divPkg::tagT     inTag,
    input  logic            branchTaken,
    input  divPkg::sqNT     branchSqN,
    input  logic            coreIdle,
    output logic            slotFull,
    output logic            startValid,
    output divPkg::divOpT   startOp,
    output divPkg::dataT    startSrcA,
    output divPkg::dataT    startSrcB,
    output divPkg::sqNT     startSqN,
    output divPkg::tagT     startTag
);
    import divPkg::*;

    logic heldKilled;
    logic inKilled;
    logic accept;

    // A flush removes the held op and blocks an arriving op younger than the branch
    assign heldKilled = branchTaken && isYounger(startSqN, branchSqN);
    assign inKilled   = branchTaken && isYounger(inSqN, branchSqN);

    // The slot only takes a new op while the whole unit is free
    assign accept = inValid && !slotFull && coreIdle && !inKilled;

    // Core captures the op on the same edge that empties the slot
    assign startValid = slotFull && coreIdle && !heldKilled;

    always_ff @(posedge clk) begin
        if (!rst) begin
            slotFull <= 1'b0;
        end else if (accept) begin
            slotFull <= 1'b1;
        end else if (startValid || heldKilled) begin
            slotFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            startOp   <= inOp;
            startSrcA <= inSrcA;
            startSrcB <= inSrcB;
            startSqN  <= inSqN;
            startTag  <= inTag;
        end
    end

endmodule

// ==== divider/divCore.sv ====
module divCore (
    input  logic            clk,
    input  logic            rst,
    input  logic            branchTaken,
    input  divPkg::sqNT     branchSqN,
    input  logic            startValid,
    input  divPkg::divOpT   startOp,
    input  divPkg::dataT    startSrcA,
    input  divPkg::dataT    startSrcB,
    input  divPkg::sqNT     startSqN,
    input  divPkg::tagT     startTag,
    output logic            coreIdle,
    output logic            doneValid,
    output divPkg::divOpT   doneOp,
    output divPkg::dataT    doneQuot,
    output divPkg::dataT    doneRem,
    output logic            doneNegQ,
    output logic            doneNegR,
    output logic            doneDivZero,
    output divPkg::dataT    doneDividend,
    output divPkg::sqNT     doneSqN,
    output divPkg::tagT     doneTag
);
    import divPkg::*;

    coreStateT state;
    stepCntT   stepCnt;
    partRemT   partRem;
    partRemT   shiftedDivisor;
    dataT      quotDigits;
    dataT      divisor;
    dataT      dividend;
    divOpT     op;
    sqNT       opSqN;
    tagT       opTag;
    logic      negQ;
    logic      negR;

    logic      signedOp;
    dataT      magA;
    dataT      magB;
    dataT      finQuot;
    dataT      finRem;
    logic      killed;

    assign signedOp = (startOp == DIV) || (startOp == REM);
    assign magA = (signedOp && startSrcA[DATA_W-1]) ? -startSrcA : startSrcA;
    assign magB = (signedOp && startSrcB[DATA_W-1]) ? -startSrcB : startSrcB;

    assign shiftedDivisor = {1'b0, divisor, {DATA_W{1'b0}}};

    // Digits are +1 where a bit is set and -1 where clear, so Q = P - N
    // A negative final remainder means the quotient overshot by one
    assign finQuot = (quotDigits - ~quotDigits) - DATA_W'(partRem[REM_W-1]);
    assign finRem  = partRem[REM_W-1] ? (partRem[REM_W-2:DATA_W] + divisor)
                                      : partRem[REM_W-2:DATA_W];

    assign killed   = branchTaken && isYounger(opSqN, branchSqN);
    assign coreIdle = (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= IDLE;
            doneValid <= 1'b0;
        end else begin
            doneValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (startValid) begin
                        state <= ITER;
                    end
                end
                ITER: begin
                    if (killed) begin
                        state <= IDLE;
                    end else if (stepCnt == '0) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state     <= IDLE;
                    doneValid <= !killed;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && startValid) begin
            stepCnt  <= stepCntT'(DATA_W - 1);
            partRem  <= {{(DATA_W + 1){1'b0}}, magA};
            divisor  <= magB;
            dividend <= startSrcA;
            op       <= startOp;
            opSqN    <= startSqN;
            opTag    <= startTag;
            negQ     <= signedOp && (startSrcA[DATA_W-1] ^ startSrcB[DATA_W-1]);
            negR     <= signedOp && startSrcA[DATA_W-1];
        end else if (state == ITER) begin
            // Subtract while the partial remainder is positive, add back otherwise
            if (!partRem[REM_W-1]) begin
                quotDigits[stepCnt] <= 1'b1;
                partRem <= {partRem[REM_W-2:0], 1'b0} - shiftedDivisor;
            end else begin
                quotDigits[stepCnt] <= 1'b0;
                partRem <= {partRem[REM_W-2:0], 1'b0} + shiftedDivisor;
            end
            stepCnt <= stepCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FINISH) begin
            doneQuot    <= finQuot;
            doneRem     <= finRem;
            doneDivZero <= (divisor == '0);
        end
    end

    // These hold from start until the next start, which is after the done strobe
    assign doneOp       = op;
    assign doneNegQ     = negQ;
    assign doneNegR     = negR;
    assign doneDividend = dividend;
    assign doneSqN      = opSqN;
    assign doneTag      = opTag;

endmodule

// ==== source/divWriteback.sv ====
module divWriteback (
    input  logic            clk,
    input  logic            rst,
    input  logic            doneValid,
    input  divPkg::divOpT   doneOp,
    input  divPkg::dataT    doneQuot,
    input  divPkg::dataT    doneRem,
    input  logic            doneNegQ,
    input  logic            doneNegR,
    input  logic            doneDivZero,
    input  divPkg::dataT    doneDividend,
    input  divPkg::sqNT     doneSqN,
    input  divPkg::tagT     doneTag,
    output logic            outValid,
    output divPkg::dataT    outResult,
    output divPkg::sqNT     outSqN,
    output divPkg::tagT     outTag
);
    import divPkg::*;

    logic isRem;
    dataT result;

    assign isRem = (doneOp == REM) || (doneOp == REMU);

    always_comb begin
        if (doneDivZero) begin
            // A zero divisor gives a quotient of all ones and returns the dividend as remainder
            result = isRem ? doneDividend : '1;
        end else if (isRem) begin
            result = doneNegR ? -doneRem : doneRem;
        end else begin
            result = doneNegQ ? -doneQuot : doneQuot;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= doneValid;
        end
    end

    always_ff @(posedge clk) begin
        if (doneValid) begin
            outResult <= result;
            outSqN    <= doneSqN;
            outTag    <= doneTag;
        end
    end

endmodule

// ==== source/divUnit.sv ====
module divUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  divPkg::divOpT   inOp,
    input  divPkg::dataT    inSrcA,
    input  divPkg::dataT    inSrcB,
    input  divPkg::sqNT     inSqN,
    input  divPkg::tagT     inTag,
    input  logic            branchTaken,
    input  divPkg::sqNT     branchSqN,
    output logic            busy,
    output logic            outValid,
    output divPkg::dataT    outResult,
    output divPkg::sqNT     outSqN,
    output divPkg::tagT     outTag
);
    import divPkg::*;

    logic  slotFull;
    logic  coreIdle;

    logic  startValid;
    divOpT startOp;
    dataT  startSrcA;
    dataT  startSrcB;
    sqNT   startSqN;
    tagT   startTag;

    logic  doneValid;
    divOpT doneOp;
    dataT  doneQuot;
    dataT  doneRem;
    logic  doneNegQ;
    logic  doneNegR;
    logic  doneDivZero;
    dataT  doneDividend;
    sqNT   doneSqN;
    tagT   doneTag;

    // Upstream must hold off while an op sits in the slot or the divider
    assign busy = slotFull || !coreIdle;

    divIssueSlot slot0 (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inOp       (inOp),
        .inSrcA     (inSrcA),
        .inSrcB     (inSrcB),
        .inSqN      (inSqN),
        .inTag      (inTag),
        .branchTaken(branchTaken),
        .branchSqN  (branchSqN),
        .coreIdle   (coreIdle),
        .slotFull   (slotFull),
        .startValid (startValid),
        .startOp    (startOp),
        .startSrcA  (startSrcA),
        .startSrcB  (startSrcB),
        .startSqN   (startSqN),
        .startTag   (startTag)
    );

    divCore core0 (
        .clk         (clk),
        .rst         (rst),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .startValid  (startValid),
        .startOp     (startOp),
        .startSrcA   (startSrcA),
        .startSrcB   (startSrcB),
        .startSqN    (startSqN),
        .startTag    (startTag),
        .coreIdle    (coreIdle),
        .doneValid   (doneValid),
        .doneOp      (doneOp),
        .doneQuot    (doneQuot),
        .doneRem     (doneRem),
        .doneNegQ    (doneNegQ),
        .doneNegR    (doneNegR),
        .doneDivZero (doneDivZero),
        .doneDividend(doneDividend),
        .doneSqN     (doneSqN),
        .doneTag     (doneTag)
    );

    divWriteback wb0 (
        .clk         (clk),
        .rst         (rst),
        .doneValid   (doneValid),
        .doneOp      (doneOp),
        .doneQuot    (doneQuot),
        .doneRem     (doneRem),
        .doneNegQ    (doneNegQ),
        .doneNegR    (doneNegR),
        .doneDivZero (doneDivZero),
        .doneDividend(doneDividend),
        .doneSqN     (doneSqN),
        .doneTag     (doneTag),
        .outValid    (outValid),
        .outResult   (outResult),
        .outSqN      (outSqN),
        .outTag      (outTag)
    );

endmodule

// ==== verif/divUnitTb.sv ====
module divUnitTb;
    import divPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESULT_LATENCY = 35;
    // One cycle in the slot, then the core stays away from IDLE for 33 more
    localparam int BUSY_CYCLES = 34;
    localparam int WAIT_LIMIT = 100;
    localparam int RANDOM_OPS = 80;

    logic        clk = 1'b0;
    logic        rst;
    logic        inValid;
    divOpT       inOp;
    dataT        inSrcA;
    dataT        inSrcB;
    sqNT         inSqN;
    tagT         inTag;
    logic        branchTaken;
    sqNT         branchSqN;
    logic        busy;
    logic        outValid;
    dataT        outResult;
    sqNT         outSqN;
    tagT         outTag;

    dataT        expResult[$];
    sqNT         expSqN[$];
    tagT         expTag[$];
    sqNT         nextSqN;
    int          mismatchCount = 0;
    int          failCount = 0;
    int unsigned seedInit;

    divUnit dut0 (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inOp       (inOp),
        .inSrcA     (inSrcA),
        .inSrcB     (inSrcB),
        .inSqN      (inSqN),
        .inTag      (inTag),
        .branchTaken(branchTaken),
        .branchSqN  (branchSqN),
        .busy       (busy),
        .outValid   (outValid),
        .outResult  (outResult),
        .outSqN     (outSqN),
        .outTag     (outTag)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // RISC-V M extension semantics, written from the ISA rules
    function automatic dataT refResult(input divOpT op, input dataT a, input dataT b);
        logic signed [DATA_W-1:0] sa;
        logic signed [DATA_W-1:0] sb;
        logic overflow;
        dataT result;
        sa = a;
        sb = b;
        overflow = (a == {1'b1, {(DATA_W - 1){1'b0}}}) && (b == '1);
        if (b == '0) begin
            result = (op == REM || op == REMU) ? a : '1;
        end else if (overflow && (op == DIV || op == REM)) begin
            result = (op == DIV) ? a : '0;
        end else begin
            case (op)
                DIV:     result = sa / sb;
                REM:     result = sa % sb;
                DIVU:    result = a / b;
                default: result = a % b;
            endcase
        end
        return result;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic endRun();
        $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        failCount++;
        endRun();
    endtask

    // Each result strobe must match the oldest op still expected
    always @(negedge clk) begin
        if (rst && outValid) begin
            assert (expResult.size() > 0) else begin
                $display("Result strobe at %0t with no op outstanding", $time);
                failCount++;
            end
            if (expResult.size() > 0) begin
                checkEqual("outResult", outResult, expResult[0]);
                checkEqual("outTag", 32'(outTag), 32'(expTag[0]));
                checkEqual("outSqN", 32'(outSqN), 32'(expSqN[0]));
                expResult.delete(0);
                expTag.delete(0);
                expSqN.delete(0);
            end
        end
    end

    // Called on a falling edge, returns one cycle later with inValid dropped
    task automatic sendOp(input divOpT op, input dataT a, input dataT b, input sqNT sqN,
                          input tagT tag, input bit expectResult);
        assert (!busy) else begin
            $display("Op sent at %0t while the unit was busy", $time);
            failCount++;
        end
        if (expectResult) begin
            expResult.push_back(refResult(op, a, b));
            expSqN.push_back(sqN);
            expTag.push_back(tag);
        end
        inValid = 1'b1;
        inOp    = op;
        inSrcA  = a;
        inSrcB  = b;
        inSqN   = sqN;
        inTag   = tag;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    // Counts edges after acceptance until the result strobe shows up
    task automatic waitResult(input int elapsed, output int cycles);
        cycles = elapsed;
        while (!outValid && cycles < WAIT_LIMIT) begin
            if (cycles < BUSY_CYCLES) begin
                checkEqual("busy", 32'(busy), 32'd1);
            end
            @(negedge clk);
            cycles++;
        end
        if (!outValid) begin
            abortOnTimeout("no result strobe after an accepted op");
        end
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            abortOnTimeout("busy never fell after a flush");
        end
    endtask

    task automatic quietCycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            checkEqual("outValid", 32'(outValid), 32'd0);
            checkEqual("busy", 32'(busy), 32'd0);
        end
    endtask

    task automatic runOp(input divOpT op, input dataT a, input dataT b);
        int cycles;
        sendOp(op, a, b, nextSqN, tagT'($urandom), 1'b1);
        nextSqN = nextSqN + sqNT'(1);
        waitResult(0, cycles);
        checkEqual("latency", cycles, RESULT_LATENCY);
        checkEqual("busy", 32'(busy), 32'd0);
    endtask

    // A delay of zero hits the op while it sits in the slot
    task automatic flushOp(input sqNT opSqN, input sqNT brSqN, input int delay,
                           input bit expectKill);
        int cycles;
        sendOp(DIV, dataT'($urandom), dataT'($urandom_range(1, 999)), opSqN,
               tagT'($urandom), !expectKill);
        repeat (delay) @(negedge clk);
        branchTaken = 1'b1;
        branchSqN   = brSqN;
        @(negedge clk);
        branchTaken = 1'b0;
        if (expectKill) begin
            waitIdle();
            quietCycles(RESULT_LATENCY + 5);
        end else begin
            waitResult(delay + 1, cycles);
            checkEqual("latency", cycles, RESULT_LATENCY);
        end
    endtask

    task automatic randomOps(input int count);
        divOpT op;
        dataT  a;
        dataT  b;
        for (int i = 0; i < count; i++) begin
            op = divOpT'($urandom_range(0, 3));
            a  = $urandom;
            case ($urandom_range(0, 3))
                0:       b = $urandom;
                1:       b = dataT'($urandom_range(1, 255));
                2:       b = -dataT'($urandom_range(1, 255));
                default: b = $urandom >> $urandom_range(0, 31);
            endcase
            runOp(op, a, b);
        end
    endtask

    initial begin
        seedInit    = $urandom(32'h6b0d);
        rst         = 1'b0;
        inValid     = 1'b0;
        inOp        = DIV;
        inSrcA      = '0;
        inSrcB      = '0;
        inSqN       = '0;
        inTag       = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
        nextSqN     = '0;
        repeat (4) @(negedge clk);
        rst = 1'b1;

        quietCycles(10);

        // Zero divisor and signed overflow
        runOp(DIV, 32'h1234_5678, 32'h0);
        runOp(DIVU, 32'h8765_4321, 32'h0);
        runOp(REM, 32'hf000_0005, 32'h0);
        runOp(REMU, 32'h0000_abcd, 32'h0);
        runOp(DIV, 32'h8000_0000, 32'hffff_ffff);
        runOp(REM, 32'h8000_0000, 32'hffff_ffff);
        runOp(DIVU, 32'h8000_0000, 32'hffff_ffff);

        // Quotients truncate toward zero for every sign combination
        runOp(DIV, 32'hffff_fff9, 32'h0000_0002);
        runOp(REM, 32'hffff_fff9, 32'h0000_0002);
        runOp(DIV, 32'h0000_0007, 32'hffff_fffe);
        runOp(REM, 32'h0000_0007, 32'hffff_fffe);
        runOp(REM, 32'hffff_fff9, 32'hffff_fffe);

        randomOps(RANDOM_OPS);

        flushOp(7'd40, 7'd37, 10, 1'b1);
        runOp(DIV, 32'hffff_ff9c, 32'h0000_0007);
        flushOp(7'd50, 7'd54, 10, 1'b0);
        flushOp(7'd20, 7'd18, 0, 1'b1);
        flushOp(7'd2, 7'd125, 0, 1'b1);
        flushOp(7'd126, 7'd1, 0, 1'b0);
        flushOp(7'd20, 7'd20, 0, 1'b0);
        runOp(REMU, 32'hdead_beef, 32'h0000_1234);

        // Let the last strobe drain and confirm it lasted one cycle
        quietCycles(2);

        assert (expResult.size() == 0) else begin
            $display("%0d expected results never arrived", expResult.size());
            failCount++;
        end
        endRun();
    end

endmodule

// ==== build.f ====
common/divPkg.sv
source/divIssueSlot.sv
divider/divCore.sv
source/divWriteback.sv
source/divUnit.sv
verif/divUnitTb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module divUnitTb -f build.f \
    -o divUnitSim \
    && ./obj_dir/divUnitSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
